/* logic/cpu_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_alu (
   input  logic [cpu_pkg::data_w-1:0] in1_i,
   input  logic [cpu_pkg::data_w-1:0] in2_i,
   input  cpu_pkg::alu_t              func_i,
   output logic [cpu_pkg::data_w-1:0] out_o,
   output logic                       c_o,
   output logic                       n_o,
   output logic                       v_o,
   output logic                       z_o
);
   import cpu_pkg::*;

   localparam int sh_w = $clog2(data_w);

   logic [data_w:0] wide;   // result with carry out
   logic            sign1;
   logic            sign2;

   assign sign1 = in1_i[data_w-1];
   assign sign2 = in2_i[data_w-1];

   always_comb begin
      wide  = '0;
      out_o = '0;
      c_o   = 1'b0;
      v_o   = 1'b0;
      case (func_i)
         alu_add: begin
            wide  = {1'b0, in1_i} + {1'b0, in2_i};
            out_o = wide[data_w-1:0];
            c_o   = wide[data_w];
            v_o   = (sign1 == sign2) && (out_o[data_w-1] != sign1);
         end
         alu_sub: begin
            wide  = {1'b0, in1_i} - {1'b0, in2_i};
            out_o = wide[data_w-1:0];
            c_o   = wide[data_w];   // borrow
            v_o   = (sign1 != sign2) && (out_o[data_w-1] != sign1);
         end
         alu_and: out_o = in1_i & in2_i;
         alu_or:  out_o = in1_i | in2_i;
         alu_xor: out_o = in1_i ^ in2_i;
         alu_shl: out_o = in1_i << in2_i[sh_w-1:0];
         alu_shr: out_o = in1_i >> in2_i[sh_w-1:0];   // logical
         default: out_o = '0;
      endcase
   end

   assign n_o = out_o[data_w-1];
   assign z_o = (out_o == '0);

endmodule

`default_nettype wire

/* logic/cpu_bus_lanes.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_bus_lanes (
   input  logic                         byte_i,
   input  logic [1:0]                   align_i,
   input  logic [cpu_pkg::data_w-1:0]   mdr_i,
   input  logic [cpu_pkg::data_w-1:0]   rdata_i,
   output logic [cpu_pkg::data_w-1:0]   wdata_o,
   output logic [cpu_pkg::data_w/8-1:0] sel_o,
   output logic [cpu_pkg::data_w-1:0]   load_o
);
   import cpu_pkg::*;

   logic [7:0] rd_byte;

   assign rd_byte = rdata_i[8*align_i +: 8];   // little endian lane

   always_comb begin
      if (byte_i) begin
         wdata_o = {(data_w/8){mdr_i[7:0]}};   // same byte on every lane
         sel_o   = (data_w/8)'(1) << align_i;
         load_o  = {{(data_w-8){1'b0}}, rd_byte};
      end else begin
         wdata_o = mdr_i;
         sel_o   = '1;
         load_o  = rdata_i;
      end
   end

endmodule

`default_nettype wire

/* logic/cpu_control.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_control (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic [cpu_pkg::data_w-1:0] ir_i,
   input  logic [2:0]                 ccr_i,
   input  logic [1:0]                 align_i,
   input  logic                       ack_i,
   output cpu_pkg::ctrl_t             ctrl_o,
   output logic                       req_o,
   output logic                       we_o,
   output logic                       byte_o,
   output logic                       halt_o
);
   import cpu_pkg::*;

   typedef enum logic [2:0] {
      s_fetch_req, s_fetch_rel, s_decode, s_execute,
      s_mem_req, s_mem_rel, s_writeback, s_halted
   } state_t;

   state_t     state;
   state_t     state_d;
   opcode_t    op;
   logic [2:0] fn;
   logic       taken;
   logic       is_mem;
   logic       is_store;
   logic       is_byte;
   logic       mem_phase;

   assign op       = opcode_t'(ir_i[op_hi:op_lo]);
   assign fn       = ir_i[fn_hi:fn_lo];
   assign is_store = (op == op_st) || (op == op_stb);
   assign is_byte  = (op == op_ldb) || (op == op_stb);
   assign is_mem   = is_store || (op == op_ld) || (op == op_ldb);

   // ccr is {carry, n^v, zero}
   always_comb begin
      case (cond_t'(fn))
         cond_always: taken = 1'b1;
         cond_eq:     taken = ccr_i[0];
         cond_ne:     taken = !ccr_i[0];
         cond_lt:     taken = ccr_i[1];
         cond_ge:     taken = !ccr_i[1];
         default:     taken = 1'b0;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i)
         state <= s_fetch_req;
      else
         state <= state_d;
   end

   always_comb begin
      ctrl_o          = '0;
      ctrl_o.rd_addr  = ir_i[rd_hi:rd_lo];
      ctrl_o.rs1_addr = ir_i[rs1_hi:rs1_lo];
      // stores read their data register through port 2
      ctrl_o.rs2_addr = is_store ? ir_i[rd_hi:rd_lo] : ir_i[rs2_hi:rs2_lo];
      ctrl_o.alu_func = ((op == op_alu) || (op == op_alui)) ? alu_t'(fn) : alu_add;
      ctrl_o.alu2_sel = (op == op_alu) ? alu2_b : alu2_imm;
      state_d         = state;
      case (state)
         s_fetch_req: begin
            if (ack_i) begin
               ctrl_o.ir_write = 1'b1;
               ctrl_o.pc_sel   = pc_next;
               state_d         = s_fetch_rel;
            end
         end
         s_fetch_rel: if (!ack_i) state_d = s_decode;
         s_decode: begin
            ctrl_o.a_write = 1'b1;
            ctrl_o.b_write = 1'b1;
            state_d        = (op == op_halt) ? s_halted : s_execute;
         end
         s_execute: begin
            case (op)
               op_alu, op_alui: ctrl_o.ccr_write = 1'b1;
               op_br:           if (taken) ctrl_o.pc_sel = pc_rel;
               op_jmp:          ctrl_o.pc_sel = pc_alu;   // rs1 + imm
               op_ld, op_ldb:   ctrl_o.mar_sel = mar_alu;
               op_st, op_stb: begin
                  ctrl_o.mar_sel = mar_alu;
                  ctrl_o.mdr_sel = mdr_b;
               end
               default: ;
            endcase
            state_d = is_mem ? s_mem_req : s_writeback;
         end
         s_mem_req: begin
            ctrl_o.addr_sel = addr_mar;
            if (ack_i) begin
               if (!is_store) ctrl_o.mdr_sel = mdr_bus;
               state_d = s_mem_rel;
            end
         end
         s_mem_rel: begin
            ctrl_o.addr_sel = addr_mar;
            if (!ack_i) state_d = s_writeback;
         end
         s_writeback: begin
            case (op)
               op_alu, op_alui: ctrl_o.reg_write = 1'b1;
               op_ldi: begin
                  ctrl_o.reg_write = 1'b1;
                  ctrl_o.reg_sel   = reg_imm;
               end
               op_ld, op_ldb: begin
                  ctrl_o.reg_write = 1'b1;
                  ctrl_o.reg_sel   = reg_mdr;
               end
               default: ;
            endcase
            state_d = s_fetch_req;
         end
         s_halted: state_d = s_halted;   // until reset
         default:  state_d = s_fetch_req;
      endcase
   end

   assign mem_phase = (state == s_mem_req) || (state == s_mem_rel);
   // low while in reset
   assign req_o     = !rst_i && ((state == s_fetch_req) || (state == s_mem_req));
   assign we_o      = (state == s_mem_req) && is_store;
   assign byte_o    = mem_phase && is_byte;
   assign halt_o    = (state == s_halted);

   // a new request waits for ack low
   a_no_req_on_ack: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (!req_o && ack_i) |=> !req_o
   );

   // word accesses stay on word boundaries
   a_word_aligned: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (req_o && !byte_o) |-> (align_i == 2'b00)
   );

endmodule

`default_nettype wire

/* logic/cpu_core.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_core (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       ack_i,
   input  logic [cpu_pkg::data_w-1:0] rdata_i,
   output cpu_pkg::bus_req_t          bus_o,
   output logic                       halt_o
);
   import cpu_pkg::*;

   ctrl_t ctrl;

   // special registers
   logic [data_w-1:0] pc;
   logic [data_w-1:0] ir;
   logic [data_w-1:0] mar;
   logic [data_w-1:0] mdr;
   logic [data_w-1:0] a;
   logic [data_w-1:0] b;
   logic [2:0]        ccr;

   logic [data_w-1:0]   pc_d;
   logic [data_w-1:0]   mar_d;
   logic [data_w-1:0]   mdr_d;
   logic [data_w-1:0]   imm_sext;
   logic [data_w-1:0]   alu_in2;
   logic [data_w-1:0]   alu_out;
   logic [data_w-1:0]   reg_wdata;
   logic [data_w-1:0]   rd1;
   logic [data_w-1:0]   rd2;
   logic [data_w-1:0]   adr;
   logic [data_w-1:0]   lane_wdata;
   logic [data_w-1:0]   lane_load;
   logic [data_w/8-1:0] lane_sel;
   logic                alu_c;
   logic                alu_n;
   logic                alu_v;
   logic                alu_z;
   logic                bus_req;
   logic                bus_we;
   logic                byte_acc;

   assign imm_sext = {{(data_w-16){ir[imm_hi]}}, ir[imm_hi:imm_lo]};
   assign adr      = (ctrl.addr_sel == addr_mar) ? mar : pc;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         pc  <= reset_pc;
         ir  <= '0;
         mar <= '0;
         mdr <= '0;
         a   <= '0;
         b   <= '0;
         ccr <= '0;
      end else begin
         pc  <= pc_d;
         mar <= mar_d;
         mdr <= mdr_d;
         if (ctrl.ir_write) ir <= rdata_i;
         if (ctrl.a_write) a <= rd1;
         if (ctrl.b_write) b <= rd2;
         if (ctrl.ccr_write) ccr <= {alu_c, alu_n ^ alu_v, alu_z};
      end
   end

   always_comb begin
      case (ctrl.pc_sel)
         pc_next: pc_d = pc + data_w'(4);
         pc_rel:  pc_d = pc + {imm_sext[data_w-3:0], 2'b00};   // from next instr
         pc_alu:  pc_d = alu_out;
         default: pc_d = pc;
      endcase
      mar_d = (ctrl.mar_sel == mar_alu) ? alu_out : mar;
      case (ctrl.mdr_sel)
         mdr_bus: mdr_d = lane_load;   // already lane aligned
         mdr_b:   mdr_d = b;
         default: mdr_d = mdr;
      endcase
      case (ctrl.reg_sel)
         reg_mdr: reg_wdata = mdr;
         reg_imm: reg_wdata = imm_sext;
         default: reg_wdata = alu_out;
      endcase
      alu_in2 = (ctrl.alu2_sel == alu2_imm) ? imm_sext : b;
   end

   assign bus_o = '{req: bus_req, we: bus_we, adr: adr, wdata: lane_wdata, sel: lane_sel};

   cpu_control u_control (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .ir_i    (ir),
      .ccr_i   (ccr),
      .align_i (adr[1:0]),
      .ack_i   (ack_i),
      .ctrl_o  (ctrl),
      .req_o   (bus_req),
      .we_o    (bus_we),
      .byte_o  (byte_acc),
      .halt_o  (halt_o)
   );

   cpu_alu u_alu (
      .in1_i  (a),
      .in2_i  (alu_in2),
      .func_i (ctrl.alu_func),
      .out_o  (alu_out),
      .c_o    (alu_c),
      .n_o    (alu_n),
      .v_o    (alu_v),
      .z_o    (alu_z)
   );

   cpu_regfile u_regfile (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .rd1_addr_i (ctrl.rs1_addr),
      .rd2_addr_i (ctrl.rs2_addr),
      .wr_addr_i  (ctrl.rd_addr),
      .wr_data_i  (reg_wdata),
      .wr_en_i    (ctrl.reg_write),
      .rd1_o      (rd1),
      .rd2_o      (rd2)
   );

   cpu_bus_lanes u_bus_lanes (
      .byte_i  (byte_acc),
      .align_i (adr[1:0]),
      .mdr_i   (mdr),
      .rdata_i (rdata_i),
      .wdata_o (lane_wdata),
      .sel_o   (lane_sel),
      .load_o  (lane_load)
   );

endmodule

`default_nettype wire

/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

   localparam int data_w = 32;
   localparam int reg_n  = 16;
   localparam int reg_aw = $clog2(reg_n);
   localparam logic [data_w-1:0] reset_pc = '0;

   // instruction layout
   localparam int op_hi  = 31;
   localparam int op_lo  = 28;
   localparam int fn_hi  = 27;
   localparam int fn_lo  = 25;
   localparam int rd_hi  = 23;
   localparam int rd_lo  = 20;
   localparam int rs1_hi = 19;
   localparam int rs1_lo = 16;
   localparam int rs2_hi = 15;
   localparam int rs2_lo = 12;
   localparam int imm_hi = 15;
   localparam int imm_lo = 0;

   typedef enum logic [3:0] {
      op_alu, op_alui, op_ldi, op_ld, op_ldb,
      op_st, op_stb, op_br, op_jmp, op_halt
   } opcode_t;

   typedef enum logic [2:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_shl, alu_shr
   } alu_t;

   typedef enum logic [2:0] {
      cond_always, cond_eq, cond_ne, cond_lt, cond_ge
   } cond_t;

   // datapath steering
   typedef enum logic [1:0] {pc_hold, pc_next, pc_rel, pc_alu} pc_sel_t;
   typedef enum logic {mar_hold, mar_alu} mar_sel_t;
   typedef enum logic [1:0] {mdr_hold, mdr_bus, mdr_b} mdr_sel_t;
   typedef enum logic [1:0] {reg_alu, reg_mdr, reg_imm} reg_sel_t;
   typedef enum logic {alu2_b, alu2_imm} alu2_sel_t;
   typedef enum logic {addr_pc, addr_mar} addr_sel_t;

   typedef struct packed {
      pc_sel_t           pc_sel;
      mar_sel_t          mar_sel;
      mdr_sel_t          mdr_sel;
      reg_sel_t          reg_sel;
      alu2_sel_t         alu2_sel;
      addr_sel_t         addr_sel;
      alu_t              alu_func;
      logic              ir_write;
      logic              a_write;
      logic              b_write;
      logic              reg_write;
      logic              ccr_write;
      logic [reg_aw-1:0] rd_addr;
      logic [reg_aw-1:0] rs1_addr;
      logic [reg_aw-1:0] rs2_addr;
   } ctrl_t;

   typedef struct packed {
      logic                req;
      logic                we;
      logic [data_w-1:0]   adr;
      logic [data_w-1:0]   wdata;
      logic [data_w/8-1:0] sel;   // byte lanes, bit 0 = adr ending in 0
   } bus_req_t;

endpackage

`default_nettype wire

/* logic/cpu_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_regfile (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic [cpu_pkg::reg_aw-1:0] rd1_addr_i,
   input  logic [cpu_pkg::reg_aw-1:0] rd2_addr_i,
   input  logic [cpu_pkg::reg_aw-1:0] wr_addr_i,
   input  logic [cpu_pkg::data_w-1:0] wr_data_i,
   input  logic                       wr_en_i,
   output logic [cpu_pkg::data_w-1:0] rd1_o,
   output logic [cpu_pkg::data_w-1:0] rd2_o
);
   import cpu_pkg::*;

   logic [data_w-1:0] regs [reg_n];

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         for (int i = 0; i < reg_n; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en_i && (wr_addr_i != '0)) begin   // r0 stays zero
         regs[wr_addr_i] <= wr_data_i;
      end
   end

   assign rd1_o = (rd1_addr_i == '0) ? '0 : regs[rd1_addr_i];
   assign rd2_o = (rd2_addr_i == '0) ? '0 : regs[rd2_addr_i];

   a_wr_addr_known: assert property (
      @(posedge clk_i) disable iff (rst_i)
      wr_en_i |-> !$isunknown(wr_addr_i)
   );

endmodule

`default_nettype wire

/* project.f */
logic/cpu_pkg.sv
logic/cpu_alu.sv
logic/cpu_regfile.sv
logic/cpu_bus_lanes.sv
logic/cpu_control.sv
logic/cpu_core.sv
test/tb_cpu.sv

/* run.sh */
#!/bin/sh
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_cpu -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/Vtb_cpu > sim.log 2>&1
if [ $? -ne 0 ]; then
   cat sim.log
   echo "simulation returned an error"
   exit 1
fi
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
   exit 0
fi
exit 1

/* test/tb_cpu.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cpu;
   import cpu_pkg::*;

   logic              clk_i = 1'b0;
   logic              rst_i;
   logic              ack_i;
   logic [data_w-1:0] rdata_i;
   bus_req_t          bus_o;
   logic              halt_o;

   logic [31:0] mem [256];   // memory seen by the dut
   logic [31:0] rmem [256];  // reference copy
   logic [31:0] prog [$];
   bus_req_t    exp_q [$];
   bus_req_t    obs_q [$];
   bus_req_t    got;
   bus_req_t    want;
   integer      seed = 91;
   int          errors = 0;
   int          tests = 0;
   longint      cycles = 0;
   longint      budget = 100;

   cpu_core dut (.clk_i(clk_i), .rst_i(rst_i), .ack_i(ack_i), .rdata_i(rdata_i),
                 .bus_o(bus_o), .halt_o(halt_o));

   always #20 clk_i = !clk_i;

   function automatic logic [31:0] r_ins(logic [3:0] op, int fn, int rd, int rs1, int rs2);
      return {op, 3'(fn), 1'b0, 4'(rd), 4'(rs1), 4'(rs2), 12'h000};
   endfunction

   function automatic logic [31:0] i_ins(logic [3:0] op, int fn, int rd, int rs1,
                                         logic [15:0] imm);
      return {op, 3'(fn), 1'b0, 4'(rd), 4'(rs1), imm};
   endfunction

   function automatic logic [31:0] fill_word(int i);
      return (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0000;
   endfunction

   // steps the program in rmem and queues every store it makes
   function automatic void ref_run();
      logic [31:0] r [16];
      logic [31:0] pc, w, x, y, res, imm, ea;
      logic [32:0] wide;
      logic [2:0]  ccr, fn;
      logic [3:0]  op, rd;
      logic [7:0]  bv;
      logic        c, v, taken, done;
      int          steps;
      bus_req_t    st;
      for (int i = 0; i < 16; i++) r[i] = '0;
      pc = 0;
      ccr = 0;
      done = 0;
      steps = 0;
      while (!done && steps < 4000) begin
         w = rmem[pc[9:2]];
         pc = pc + 4;
         steps++;
         op = w[31:28];
         fn = w[27:25];
         rd = w[23:20];
         imm = {{16{w[15]}}, w[15:0]};
         x = r[w[19:16]];
         y = (op == op_alu) ? r[w[15:12]] : imm;
         c = 0;
         v = 0;
         wide = '0;
         case (fn)
            0: begin
               wide = {1'b0, x} + {1'b0, y};
               v = (x[31] == y[31]) && (wide[31] != x[31]);
            end
            1: begin
               wide = {1'b0, x} - {1'b0, y};
               v = (x[31] != y[31]) && (wide[31] != x[31]);
            end
            2: wide = {1'b0, x & y};
            3: wide = {1'b0, x | y};
            4: wide = {1'b0, x ^ y};
            5: wide = {1'b0, x << y[4:0]};
            6: wide = {1'b0, x >> y[4:0]};
            default: wide = '0;
         endcase
         res = wide[31:0];
         c = wide[32];
         ea = x + imm;
         st = '{req: 1'b1, we: 1'b1, adr: ea, wdata: r[rd], sel: 4'hf};
         case (op)
            op_alu, op_alui: begin
               if (rd != 0) r[rd] = res;
               ccr = {c, res[31] ^ v, res == 0};
            end
            op_ldi: if (rd != 0) r[rd] = imm;
            op_ld:  if (rd != 0) r[rd] = rmem[ea[9:2]];
            op_ldb: begin
               w = rmem[ea[9:2]];
               bv = w[8*ea[1:0] +: 8];
               if (rd != 0) r[rd] = {24'h0, bv};
            end
            op_st: begin
               rmem[ea[9:2]] = r[rd];
               exp_q.push_back(st);
            end
            op_stb: begin
               rmem[ea[9:2]][8*ea[1:0] +: 8] = r[rd][7:0];
               st.wdata = {4{r[rd][7:0]}};
               st.sel = 4'b0001 << ea[1:0];
               exp_q.push_back(st);
            end
            op_br: begin
               case (fn)
                  0: taken = 1;
                  1: taken = ccr[0];
                  2: taken = !ccr[0];
                  3: taken = ccr[1];
                  4: taken = !ccr[1];
                  default: taken = 0;
               endcase
               if (taken) pc = pc + {imm[29:0], 2'b00};
            end
            op_jmp: pc = ea;
            default: done = 1;   // halt
         endcase
      end
   endfunction

   // memory responder, acts 2 ns after each rising edge
   initial begin
      int       phase;
      int       cnt;
      logic     req_prev;
      bus_req_t held;
      phase = 0;
      cnt = 0;
      req_prev = 0;
      held = '0;
      forever begin
         @(posedge clk_i);
         #2;
         if (rst_i) begin
            phase = 0;
            ack_i = 0;
         end else begin
            assert (!(bus_o.req && !req_prev && ack_i))
               else begin
                  $display("request raised while ack still high");
                  errors++;
               end
            assert (!(bus_o.req && req_prev && phase == 1 &&
                      (bus_o.adr != held.adr || bus_o.we != held.we)))
               else begin
                  $display("address or write enable changed while req high");
                  errors++;
               end
            if (phase == 0 && bus_o.req) begin
               held = bus_o;
               cnt = $random(seed) & 3;
               phase = 1;
            end
            if (phase == 1) begin
               if (cnt == 0) begin
                  ack_i = 1;
                  if (bus_o.we) begin
                     for (int l = 0; l < 4; l++)
                        if (bus_o.sel[l]) mem[bus_o.adr[9:2]][8*l +: 8] = bus_o.wdata[8*l +: 8];
                     obs_q.push_back(bus_o);
                  end else begin
                     rdata_i = mem[bus_o.adr[9:2]];
                  end
                  phase = 2;
               end else begin
                  cnt--;
               end
            end else if (phase == 2 && !bus_o.req) begin
               cnt = $random(seed) & 3;
               phase = 3;
            end else if (phase == 3) begin
               if (cnt == 0) begin
                  ack_i = 0;
                  phase = 0;
               end else begin
                  cnt--;
               end
            end
         end
         req_prev = bus_o.req;
      end
   end

   // compares observed writes with the reference stores
   always @(posedge clk_i) begin
      while (obs_q.size() > 0) begin
         got = obs_q.pop_front();
         if (exp_q.size() == 0) begin
            $display("unexpected store to address %h", got.adr);
            errors++;
         end else begin
            want = exp_q.pop_front();
            assert (got.adr == want.adr)
               else begin
                  $display("FAIL adr got %h expected %h", got.adr, want.adr);
                  errors++;
               end
            assert (got.wdata == want.wdata)
               else begin
                  $display("FAIL wdata got %h expected %h", got.wdata, want.wdata);
                  errors++;
               end
            assert (got.sel == want.sel)
               else begin
                  $display("FAIL sel got %h expected %h", got.sel, want.sel);
                  errors++;
               end
         end
      end
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles > budget) begin
         $display("timeout, the core did not halt in time");
         $display("ERRORS FOUND");
         $finish;
      end
   end

   task automatic run_test(string name);
      int e0;
      int n;
      e0 = errors;
      for (int i = 0; i < 256; i++) mem[i] = fill_word(i);
      foreach (prog[i]) mem[i] = prog[i];
      rmem = mem;
      exp_q.delete();
      ref_run();
      n = exp_q.size();
      budget = budget + prog.size() * 200 * 4 + 100;   // worst ack delay is about 4 cycles
      @(posedge clk_i);
      #2 rst_i = 1;
      repeat (5) @(posedge clk_i);
      #2;
      assert (!bus_o.req && !bus_o.we && !halt_o)
         else begin
            $display("FAIL bus_o.req, bus_o.we, halt_o in reset got %h %h %h expected 0",
                     bus_o.req, bus_o.we, halt_o);
            errors++;
         end
      rst_i = 0;
      while (!halt_o) begin
         @(posedge clk_i);
         #2;
      end
      repeat (50) begin
         @(posedge clk_i);
         #2;
         assert (!bus_o.req)
            else begin
               $display("request seen after halt at address %h", bus_o.adr);
               errors++;
            end
      end
      if (exp_q.size() != 0) begin
         $display("%0d expected stores never appeared", exp_q.size());
         errors++;
      end
      tests++;
      $display("%s: %0d stores, %s", name, n, (errors == e0) ? "ok" : "failed");
      prog.delete();
   endtask

   initial begin
      int idx;
      int xs [4];
      int ys [4];
      rst_i = 1;
      ack_i = 0;
      rdata_i = '0;
      xs = '{1, 2, 1, 6};
      ys = '{2, 1, 1, 1};

      prog.push_back(i_ins(op_ldi, 0, 1, 0, 16'h1234));
      prog.push_back(i_ins(op_ldi, 0, 2, 0, 16'hfffd));
      prog.push_back(i_ins(op_ldi, 0, 3, 0, 16'h0005));
      for (int f = 0; f < 7; f++) begin
         prog.push_back(r_ins(op_alu, f, 4, (f == 6) ? 2 : 1, (f >= 5) ? 3 : 2));
         prog.push_back(i_ins(op_st, 0, 4, 0, 16'(16'h200 + 4 * f)));
      end
      prog.push_back(i_ins(op_halt, 0, 0, 0, 0));
      run_test("register alu");

      prog.push_back(i_ins(op_ldi, 0, 1, 0, 16'h7000));
      for (int f = 0; f < 7; f++) begin
         prog.push_back(i_ins(op_alui, f, 4, 1, 16'(16'hfff0 + f)));
         prog.push_back(i_ins(op_st, 0, 4, 0, 16'(16'h240 + 4 * f)));
      end
      prog.push_back(i_ins(op_ldi, 0, 0, 0, 16'h0055));
      prog.push_back(i_ins(op_st, 0, 0, 0, 16'h0260));
      prog.push_back(i_ins(op_halt, 0, 0, 0, 0));
      run_test("immediate alu and r0");

      prog.push_back(i_ins(op_ldi, 0, 1, 0, 16'h1a2b));
      prog.push_back(i_ins(op_alui, alu_shl, 1, 1, 16'd16));
      prog.push_back(i_ins(op_alui, alu_or, 1, 1, 16'h3c4d));
      for (int k = 0; k < 4; k++) begin
         prog.push_back(i_ins(op_stb, 0, 1, 0, 16'(16'h300 + k)));
         prog.push_back(i_ins(op_alui, alu_shr, 1, 1, 16'd8));
      end
      for (int k = 0; k < 4; k++) begin
         prog.push_back(i_ins(op_ldb, 0, 2, 0, 16'(16'h380 + k)));
         prog.push_back(i_ins(op_st, 0, 2, 0, 16'(16'h3c0 + 4 * k)));
         prog.push_back(i_ins(op_ldb, 0, 2, 0, 16'(16'h300 + k)));
         prog.push_back(i_ins(op_st, 0, 2, 0, 16'(16'h3d0 + 4 * k)));
      end
      prog.push_back(i_ins(op_halt, 0, 0, 0, 0));
      run_test("byte lanes");

      prog.push_back(i_ins(op_ldi, 0, 1, 0, 16'd5));
      prog.push_back(i_ins(op_ldi, 0, 2, 0, 16'd7));
      prog.push_back(i_ins(op_ldi, 0, 6, 0, 16'hfffe));
      idx = 0;
      for (int c = 0; c < 5; c++) begin
         for (int p = 0; p < 4; p++) begin
            prog.push_back(r_ins(op_alu, alu_sub, 3, xs[p], ys[p]));
            prog.push_back(i_ins(op_br, c, 0, 0, 16'd1));   // skips the next store
            prog.push_back(i_ins(op_st, 0, 1, 0, 16'(16'h200 + 8 * idx)));
            prog.push_back(i_ins(op_st, 0, 2, 0, 16'(16'h204 + 8 * idx)));
            idx++;
         end
      end
      prog.push_back(i_ins(op_ldi, 0, 4, 0, 16'd3));
      prog.push_back(i_ins(op_st, 0, 4, 0, 16'h02c0));   // loop body
      prog.push_back(i_ins(op_alui, alu_sub, 4, 4, 16'd1));
      prog.push_back(i_ins(op_br, cond_ne, 0, 0, 16'hfffd));
      prog.push_back(i_ins(op_ldi, 0, 5, 0, 16'(4 * (prog.size() + 3))));
      prog.push_back(i_ins(op_jmp, 0, 0, 5, 16'd0));
      prog.push_back(i_ins(op_st, 0, 1, 0, 16'h02c4));
      prog.push_back(i_ins(op_st, 0, 2, 0, 16'h02c8));
      prog.push_back(i_ins(op_halt, 0, 0, 0, 0));
      run_test("branches and jump");

      $display("tests %0d, errors %0d", tests, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire
